// File: files.f
+incdir+verification
src/fleetPkg.sv
src/shipCellDecoder.sv
src/overlapScanner.sv
src/fleetStore.sv
src/placementControl.sv
src/shipValidator.sv
verification/validatorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the ship validator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module validatorTb -f files.f

output=$(./obj_dir/VvalidatorTb)
echo "$output"

echo "$output" | grep -qx "NO ERRORS"

// File: src/fleetPkg.sv
package fleetPkg;

	//******************************************************************
	// Board and fleet sizes
	//******************************************************************
	localparam int boardSize = 8;
	localparam int maxCells = 5;
	localparam int fleetDepth = 11;

	// One board coordinate wide enough to show an off-board result
	typedef logic [3:0] coordT;

	// Store index and entry count
	typedef logic [3:0] entryIdxT;

	// Codes 5 to 7 are illegal
	typedef enum logic [2:0]
	{
		submarine = 3'd0,
		cruiser = 3'd1,
		seaplane = 3'd2,
		battleship = 3'd3,
		carrier = 3'd4
	} shipKindT;

	typedef struct packed
	{
		coordT x;
		coordT y;
	} cellT;

	// Slots at or above cellCount are zero and never compared
	typedef struct packed
	{
		shipKindT kind;
		logic [2:0] cellCount;
		cellT [maxCells-1:0] cells;
	} shipRecordT;

	// direction is 0 for horizontal, 1 for vertical
	typedef struct packed
	{
		shipKindT kind;
		logic player;
		coordT x;
		coordT y;
		logic direction;
		logic [1:0] orientation;
	} placeRequestT;

	typedef enum logic [2:0]
	{
		idle = 3'd0,
		checkBorder = 3'd1,
		borderConflict = 3'd2,
		scanFleet = 3'd3,
		memoryConflict = 3'd4,
		saving = 3'd5
	} placeStateT;

endpackage

// File: src/fleetStore.sv
`timescale 1ns/10ps

module fleetStore
(
	input logic clk,
	input logic rstN,
	input logic player,
	input logic writeStrobe,
	input fleetPkg::shipRecordT writeRecord,
	input fleetPkg::entryIdxT readIdx,
	output fleetPkg::shipRecordT readRecord,
	output fleetPkg::entryIdxT entryCount
);

	//******************************************************************
	// One bank and one count per player
	//******************************************************************
	fleetPkg::shipRecordT bank [2][fleetPkg::fleetDepth];
	fleetPkg::entryIdxT count [2];

	assign readRecord = bank[player][readIdx];
	assign entryCount = count[player];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			count[0] <= '0;
			count[1] <= '0;
		end
		else if (writeStrobe)
			count[player] <= count[player] + 4'd1;
	end

	// Append at the current count
	always_ff @(posedge clk)
	begin
		if (writeStrobe)
			bank[player][count[player]] <= writeRecord;
	end

	noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
		writeStrobe |-> entryCount != fleetPkg::entryIdxT'(fleetPkg::fleetDepth));

endmodule

// File: src/overlapScanner.sv
`timescale 1ns/10ps

module overlapScanner
(
	input logic clk,
	input logic rstN,
	input logic scanStart,
	input fleetPkg::shipRecordT newRecord,
	input fleetPkg::entryIdxT entryCount,
	output fleetPkg::entryIdxT readIdx,
	input fleetPkg::shipRecordT readRecord,
	output logic scanDone,
	output logic hit
);

	logic busy;
	logic cellMatch;
	logic fleetEmpty;
	logic fleetFull;
	logic lastEntry;

	assign fleetEmpty = (entryCount == '0);
	assign fleetFull = (entryCount == fleetPkg::entryIdxT'(fleetPkg::fleetDepth));
	assign lastEntry = (readIdx == entryCount - 4'd1);

	// Any used cell of the new ship on any used cell of the stored one
	always_comb
	begin
		cellMatch = 1'b0;
		for (int i = 0; i < fleetPkg::maxCells; i++)
		begin
			for (int j = 0; j < fleetPkg::maxCells; j++)
			begin
				if (i < newRecord.cellCount && j < readRecord.cellCount
					&& newRecord.cells[i] == readRecord.cells[j])
					cellMatch = 1'b1;
			end
		end
	end

	//******************************************************************
	// Walk the fleet one entry per cycle
	//******************************************************************
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			readIdx <= '0;
			scanDone <= 1'b0;
			hit <= 1'b0;
		end
		else
		begin
			scanDone <= 1'b0;
			if (scanStart)
			begin
				busy <= 1'b1;
				readIdx <= '0;
				hit <= 1'b0;
			end
			else if (busy)
			begin
				if (fleetFull || fleetEmpty || cellMatch || lastEntry)
				begin
					busy <= 1'b0;
					scanDone <= 1'b1;
					// A full fleet has no room, so it counts as a conflict
					hit <= fleetFull || (!fleetEmpty && cellMatch);
				end
				else
					readIdx <= readIdx + 4'd1;
			end
		end
	end

	readIdxInRange: assert property (@(posedge clk) disable iff (!rstN)
		busy |-> readIdx < fleetPkg::entryIdxT'(fleetPkg::fleetDepth));

endmodule

// File: src/placementControl.sv
`timescale 1ns/10ps

module placementControl
(
	input logic clk,
	input logic rstN,
	input logic enable,
	input logic onBoard,
	input logic scanDone,
	input logic hit,
	output logic decodeStrobe,
	output logic scanStart,
	output logic writeStrobe,
	output logic placed,
	output logic borderConflict,
	output logic memoryConflict
);

	fleetPkg::placeStateT state;
	fleetPkg::placeStateT nextState;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state <= fleetPkg::idle;
		else
			state <= nextState;
	end

	//******************************************************************
	// Next state
	//******************************************************************
	always_comb
	begin
		nextState = state;
		case (state)
			fleetPkg::idle:
				if (enable)
					nextState = fleetPkg::checkBorder;
			fleetPkg::checkBorder:
				nextState = onBoard ? fleetPkg::scanFleet : fleetPkg::borderConflict;
			fleetPkg::scanFleet:
				if (scanDone)
					nextState = hit ? fleetPkg::memoryConflict : fleetPkg::saving;
			// Result states hold until the requester lets go
			fleetPkg::borderConflict, fleetPkg::memoryConflict, fleetPkg::saving:
				if (!enable)
					nextState = fleetPkg::idle;
			default: nextState = fleetPkg::idle;
		endcase
	end

	// Strobes fire on the transitions
	assign decodeStrobe = (state == fleetPkg::idle) && enable;
	assign scanStart = (state == fleetPkg::checkBorder) && onBoard;
	assign writeStrobe = (state == fleetPkg::scanFleet) && scanDone && !hit;

	assign placed = (state == fleetPkg::saving);
	assign borderConflict = (state == fleetPkg::borderConflict);
	assign memoryConflict = (state == fleetPkg::memoryConflict);

	placedExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(placed && (borderConflict || memoryConflict)));

endmodule

// File: src/shipCellDecoder.sv
`timescale 1ns/10ps

module shipCellDecoder
(
	input logic clk,
	input logic rstN,
	input logic decodeStrobe,
	input fleetPkg::placeRequestT request,
	output fleetPkg::shipRecordT record,
	output logic onBoard
);

	fleetPkg::shipRecordT nextRecord;
	logic nextOnBoard;
	logic kindLegal;
	logic straightLine;

	//******************************************************************
	// Cell generation
	//******************************************************************
	always_comb
	begin
		nextRecord = '0;
		kindLegal = 1'b1;
		straightLine = 1'b1;
		nextRecord.kind = request.kind;
		nextRecord.cells[0].x = request.x;
		nextRecord.cells[0].y = request.y;

		case (request.kind)
			fleetPkg::submarine: nextRecord.cellCount = 3'd1;
			fleetPkg::cruiser: nextRecord.cellCount = 3'd2;
			fleetPkg::battleship: nextRecord.cellCount = 3'd4;
			fleetPkg::carrier: nextRecord.cellCount = 3'd5;
			fleetPkg::seaplane:
			begin
				nextRecord.cellCount = 3'd3;
				straightLine = 1'b0;
			end
			default:
			begin
				kindLegal = 1'b0;
				straightLine = 1'b0;
				nextRecord.cells[0] = '0;
			end
		endcase

		// Straight ships step along one axis from the anchor
		if (straightLine)
		begin
			for (int i = 1; i < fleetPkg::maxCells; i++)
			begin
				if (i < nextRecord.cellCount)
				begin
					nextRecord.cells[i].x = request.direction ? request.x
						: request.x + fleetPkg::coordT'(i);
					nextRecord.cells[i].y = request.direction ? request.y + fleetPkg::coordT'(i)
						: request.y;
				end
			end
		end

		// Seaplane shape follows the orientation and ignores direction
		if (request.kind == fleetPkg::seaplane)
		begin
			case (request.orientation)
				2'd0:
				begin
					nextRecord.cells[1] = '{x: request.x + 4'd1, y: request.y + 4'd1};
					nextRecord.cells[2] = '{x: request.x + 4'd2, y: request.y};
				end
				2'd1:
				begin
					nextRecord.cells[1] = '{x: request.x + 4'd1, y: request.y - 4'd1};
					nextRecord.cells[2] = '{x: request.x + 4'd2, y: request.y};
				end
				2'd2:
				begin
					nextRecord.cells[1] = '{x: request.x + 4'd1, y: request.y + 4'd1};
					nextRecord.cells[2] = '{x: request.x, y: request.y + 4'd2};
				end
				default:
				begin
					nextRecord.cells[1] = '{x: request.x - 4'd1, y: request.y + 4'd1};
					nextRecord.cells[2] = '{x: request.x, y: request.y + 4'd2};
				end
			endcase
		end

		// Border check over the used slots only
		nextOnBoard = kindLegal;
		for (int i = 0; i < fleetPkg::maxCells; i++)
		begin
			if (i < nextRecord.cellCount && (nextRecord.cells[i].x >= fleetPkg::boardSize
				|| nextRecord.cells[i].y >= fleetPkg::boardSize))
				nextOnBoard = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			onBoard <= 1'b0;
		else if (decodeStrobe)
			onBoard <= nextOnBoard;
	end

	always_ff @(posedge clk)
	begin
		if (decodeStrobe)
			record <= nextRecord;
	end

	cellCountLimit: assert property (@(posedge clk) disable iff (!rstN)
		decodeStrobe |=> record.cellCount <= 3'(fleetPkg::maxCells));

endmodule

// File: src/shipValidator.sv
`timescale 1ns/10ps

module shipValidator
(
	input logic clk,
	input logic rstN,
	input logic enable,
	input fleetPkg::placeRequestT request,
	output logic placed,
	output logic borderConflict,
	output logic memoryConflict,
	output logic conflict
);

	fleetPkg::shipRecordT record;
	fleetPkg::shipRecordT readRecord;
	fleetPkg::entryIdxT readIdx;
	fleetPkg::entryIdxT entryCount;
	logic onBoard;
	logic decodeStrobe;
	logic scanStart;
	logic scanDone;
	logic hit;
	logic writeStrobe;
	logic latchedPlayer;

	// Player held for the scan and the write
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			latchedPlayer <= 1'b0;
		else if (decodeStrobe)
			latchedPlayer <= request.player;
	end

	shipCellDecoder decoder
	(
		.clk(clk),
		.rstN(rstN),
		.decodeStrobe(decodeStrobe),
		.request(request),
		.record(record),
		.onBoard(onBoard)
	);

	overlapScanner scanner
	(
		.clk(clk),
		.rstN(rstN),
		.scanStart(scanStart),
		.newRecord(record),
		.entryCount(entryCount),
		.readIdx(readIdx),
		.readRecord(readRecord),
		.scanDone(scanDone),
		.hit(hit)
	);

	fleetStore store
	(
		.clk(clk),
		.rstN(rstN),
		.player(latchedPlayer),
		.writeStrobe(writeStrobe),
		.writeRecord(record),
		.readIdx(readIdx),
		.readRecord(readRecord),
		.entryCount(entryCount)
	);

	placementControl control
	(
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.onBoard(onBoard),
		.scanDone(scanDone),
		.hit(hit),
		.decodeStrobe(decodeStrobe),
		.scanStart(scanStart),
		.writeStrobe(writeStrobe),
		.placed(placed),
		.borderConflict(borderConflict),
		.memoryConflict(memoryConflict)
	);

	assign conflict = borderConflict | memoryConflict;

endmodule

// File: verification/validatorModel.svh
// Outcome codes of the reference function
localparam int outcomePlaced = 0;
localparam int outcomeBorder = 1;
localparam int outcomeMemory = 2;

// Model fleet per player as an occupancy grid plus an entry count
bit occupied [2][fleetPkg::boardSize][fleetPkg::boardSize];
int modelCount [2];

function automatic void clearModel();
	for (int p = 0; p < 2; p++)
	begin
		modelCount[p] = 0;
		for (int cx = 0; cx < fleetPkg::boardSize; cx++)
			for (int cy = 0; cy < fleetPkg::boardSize; cy++)
				occupied[p][cx][cy] = 1'b0;
	end
endfunction

function automatic fleetPkg::placeRequestT makeRequest(input int kind, input int player,
	input int x, input int y, input int direction, input int orientation);
	fleetPkg::placeRequestT req;
	req.kind = fleetPkg::shipKindT'(kind[2:0]);
	req.player = player[0];
	req.x = fleetPkg::coordT'(x);
	req.y = fleetPkg::coordT'(y);
	req.direction = direction[0];
	req.orientation = orientation[1:0];
	return req;
endfunction

// Zero means an illegal kind code
function automatic int shipLength(input fleetPkg::placeRequestT req);
	case (req.kind)
		fleetPkg::submarine: return 1;
		fleetPkg::cruiser: return 2;
		fleetPkg::seaplane: return 3;
		fleetPkg::battleship: return 4;
		fleetPkg::carrier: return 5;
		default: return 0;
	endcase
endfunction

// Cell i of the ship in signed board coordinates
function automatic void shipCell(input fleetPkg::placeRequestT req, input int i,
	output int cx, output int cy);
	cx = int'(req.x);
	cy = int'(req.y);
	if (req.kind == fleetPkg::seaplane)
	begin
		if (i == 1)
		begin
			cx += (req.orientation == 2'd3) ? -1 : 1;
			cy += (req.orientation == 2'd1) ? -1 : 1;
		end
		else if (i == 2)
		begin
			cx += (req.orientation < 2'd2) ? 2 : 0;
			cy += (req.orientation < 2'd2) ? 0 : 2;
		end
	end
	else if (req.direction)
		cy += i;
	else
		cx += i;
endfunction

//**********************************************************************
// Reference outcome checks the border first, then a full fleet, then overlap
//**********************************************************************
function automatic int expectedOutcome(input fleetPkg::placeRequestT req);
	int len;
	int cx;
	int cy;
	len = shipLength(req);
	if (len == 0)
		return outcomeBorder;
	for (int i = 0; i < len; i++)
	begin
		shipCell(req, i, cx, cy);
		if (cx < 0 || cx >= fleetPkg::boardSize || cy < 0 || cy >= fleetPkg::boardSize)
			return outcomeBorder;
	end
	if (modelCount[req.player] == fleetPkg::fleetDepth)
		return outcomeMemory;
	for (int i = 0; i < len; i++)
	begin
		shipCell(req, i, cx, cy);
		if (occupied[req.player][cx][cy])
			return outcomeMemory;
	end
	return outcomePlaced;
endfunction

function automatic void commitShip(input fleetPkg::placeRequestT req);
	int cx;
	int cy;
	for (int i = 0; i < shipLength(req); i++)
	begin
		shipCell(req, i, cx, cy);
		occupied[req.player][cx][cy] = 1'b1;
	end
	modelCount[req.player]++;
endfunction

function automatic bit statusMatches(input int outcome);
	return placed == (outcome == outcomePlaced) && borderConflict == (outcome == outcomeBorder)
		&& memoryConflict == (outcome == outcomeMemory) && conflict == (outcome != outcomePlaced);
endfunction

// Drive one request, wait for its result, hold, then release
task automatic sendRequest(input fleetPkg::placeRequestT req, input int holdCycles);
	int startCount;
	int waited;
	expOutcome = expectedOutcome(req);
	if (expOutcome == outcomePlaced)
		commitShip(req);
	startCount = resultCount;
	@(posedge clk);
	request <= req;
	enable <= 1'b1;
	waited = 0;
	while (resultCount == startCount && waited < fleetPkg::fleetDepth + 8)
	begin
		@(posedge clk);
		waited++;
	end
	if (resultCount == startCount)
	begin
		$display("No result arrived within %0d cycles for request %h", waited, req);
		stimErrors++;
	end
	else
	begin
		repeat (holdCycles)
		begin
			@(posedge clk);
			assert (statusMatches(expOutcome))
			else
			begin
				$display("[ERROR] %0t: status changed while enable was held", $time);
				stimErrors++;
			end
		end
	end
	enable <= 1'b0;
	repeat (2) @(posedge clk);
	assert (!(placed || borderConflict || memoryConflict || conflict))
	else
	begin
		$display("[ERROR] %0t: status still high after enable dropped", $time);
		stimErrors++;
	end
	requestCount++;
endtask

// File: verification/validatorTb.sv
`timescale 1ns/10ps

module validatorTb;

	localparam int randomCount = 200;
	// Directed requests of tests 1 to 4 and 6 plus the random ones
	localparam int requestTotal = 5 + 8 + 2 + 12 + randomCount + 1;
	localparam int watchdogCycles = requestTotal * (fleetPkg::fleetDepth + 10);

	logic clk;
	logic rstN;
	logic enable;
	fleetPkg::placeRequestT request;
	logic placed;
	logic borderConflict;
	logic memoryConflict;
	logic conflict;

	int expOutcome = 0;
	int resultCount = 0;
	int compareErrors = 0;
	int stimErrors = 0;
	int requestCount = 0;
	int markRequests = 0;
	int markErrors = 0;
	logic statusSeen;

	`include "validatorModel.svh"

	shipValidator dut
	(
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.request(request),
		.placed(placed),
		.borderConflict(borderConflict),
		.memoryConflict(memoryConflict),
		.conflict(conflict)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	//******************************************************************
	// Compare the first cycle of each result with the reference
	//******************************************************************
	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			statusSeen <= 1'b0;
		else if (placed || borderConflict || memoryConflict)
		begin
			if (!statusSeen)
			begin
				assert (statusMatches(expOutcome))
				else
				begin
					// Status bits in the order placed, border, memory, conflict
					$display("[ERROR] %0t: expected outcome %0d, got status %b%b%b%b",
						$time, expOutcome, placed, borderConflict, memoryConflict, conflict);
					compareErrors <= compareErrors + 1;
				end
				resultCount <= resultCount + 1;
			end
			statusSeen <= 1'b1;
		end
		else
			statusSeen <= 1'b0;
	end

	initial
	begin
		#((watchdogCycles + 40) * 10);
		$display("Watchdog expired after %0d cycles before the tests finished", watchdogCycles);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic applyReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		clearModel();
	endtask

	task automatic beginTest();
		markRequests = requestCount;
		markErrors = stimErrors + compareErrors;
	endtask

	task automatic endTest(input int number, input string name);
		$display("Test %0d %s: %0d requests, %0d errors", number, name,
			requestCount - markRequests, stimErrors + compareErrors - markErrors);
	endtask

	initial
	begin
		void'($urandom(32'h5547));
		rstN <= 1'b0;
		enable <= 1'b0;
		request <= '0;
		clearModel();
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		beginTest();
		sendRequest(makeRequest(0, 0, 0, 0, 0, 0), 1);
		sendRequest(makeRequest(1, 0, 2, 0, 0, 0), 1);
		sendRequest(makeRequest(2, 0, 0, 2, 0, 0), 1);
		sendRequest(makeRequest(3, 0, 4, 1, 1, 0), 1);
		sendRequest(makeRequest(4, 0, 0, 7, 0, 0), 1);
		endTest(1, "legal kinds");

		// First off-board anchor per straight kind, then each seaplane orientation
		beginTest();
		sendRequest(makeRequest(0, 0, 8, 5, 0, 0), 1);
		sendRequest(makeRequest(1, 0, 7, 5, 0, 0), 1);
		sendRequest(makeRequest(3, 0, 5, 5, 0, 0), 1);
		sendRequest(makeRequest(4, 0, 4, 5, 0, 0), 1);
		sendRequest(makeRequest(2, 0, 6, 3, 0, 0), 1);
		sendRequest(makeRequest(2, 0, 2, 0, 0, 1), 1);
		sendRequest(makeRequest(2, 0, 3, 6, 0, 2), 1);
		sendRequest(makeRequest(2, 0, 0, 3, 0, 3), 1);
		endTest(2, "border conflicts");

		beginTest();
		sendRequest(makeRequest(1, 0, 3, 0, 0, 0), 1);
		sendRequest(makeRequest(1, 1, 3, 0, 0, 0), 1);
		endTest(3, "overlap per player");

		beginTest();
		applyReset();
		for (int i = 0; i <= fleetPkg::fleetDepth; i++)
			sendRequest(makeRequest(0, 0, i % 8, i / 8 * 3, 0, 0), 1);
		endTest(4, "full fleet");

		beginTest();
		applyReset();
		for (int n = 0; n < randomCount; n++)
			sendRequest(makeRequest($urandom % 8, $urandom % 2, $urandom % 9, $urandom % 9,
				$urandom % 2, $urandom % 4), 0);
		endTest(5, "random requests");

		beginTest();
		sendRequest(makeRequest(0, 1, 7, 7, 0, 0), 6);
		endTest(6, "status hold");

		$display("Summary: %0d requests, %0d failed checks", requestCount,
			stimErrors + compareErrors);
		if (stimErrors + compareErrors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
